//--- hdl/rv_core_config.svh
// RV32I core configuration

`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// First fetch address after reset
`define RV_RESET_ADDR 32'h0000_0000

// Architectural register count, x0 included
`define RV_NUM_REGS 32

`endif

//--- hdl/rv_core_pkg.sv
// RV32I core types

package rv_core_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

  typedef enum logic [1:0] {SRC_A_REG, SRC_A_PC, SRC_A_OLD_PC, SRC_A_ZERO} src_a_e;
  typedef enum logic [1:0] {SRC_B_REG, SRC_B_IMM, SRC_B_FOUR} src_b_e;
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

  typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEM, WRITEBACK, HALT} state_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  // Also carries the B format, whose bits sit in the same fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_fmt_t;

  // Also carries the J format
  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    u_fmt_t u_fmt;
  } instr_u;

endpackage

//--- hdl/rv_decode.sv
// Multicycle control FSM
`timescale 1ns/1ps

module rv_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_core_pkg::instr_u  instr,
  input  logic                 branch_taken,
  input  logic                 mem_ready,
  output rv_core_pkg::state_e  state_q,
  output logic                 ir_load,
  output logic                 pc_load,
  output logic                 old_pc_load,
  output rv_core_pkg::alu_op_e alu_op,
  output rv_core_pkg::src_a_e  src_a,
  output rv_core_pkg::src_b_e  src_b,
  output rv_core_pkg::imm_sel_e imm_sel,
  output rv_core_pkg::wb_sel_e wb_sel,
  output logic                 reg_we,
  output logic                 addr_sel,
  output logic                 mem_valid,
  output logic                 mem_we,
  output logic                 retired,
  output logic                 halted
);
  import rv_core_pkg::*;

  state_e  state_d;
  opcode_e opcode;
  logic [2:0] funct3;
  logic    funct7_b5;
  logic    hs;
  logic    is_store;
  logic    known;
  alu_op_e arith_op;

  assign opcode    = instr.r_fmt.opcode;
  assign funct3    = instr.r_fmt.funct3;
  assign funct7_b5 = instr.r_fmt.funct7[5];
  assign hs        = mem_valid & mem_ready;  // Transfer on this edge
  assign is_store  = (opcode == OPC_STORE);

  // Word access only, SYSTEM falls out as unknown
  always_comb begin
    case (opcode)
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
      OPC_JAL, OPC_JALR, OPC_BRANCH: known = 1'b1;
      OPC_LOAD, OPC_STORE:           known = (funct3 == 3'b010);
      default:                       known = 1'b0;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;  // SRAI uses imm bit 10
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  // Request is registered, raised on entry to FETCH or MEM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= FETCH;
      mem_valid <= 1'b0;
    end else begin
      state_q   <= state_d;
      mem_valid <= (state_d == FETCH) || (state_d == MEM);
    end
  end

  always_comb begin
    state_d     = state_q;
    ir_load     = 1'b0;
    pc_load     = 1'b0;
    old_pc_load = 1'b0;
    alu_op      = ALU_ADD;     // PC + 4 by default
    src_a       = SRC_A_PC;
    src_b       = SRC_B_FOUR;
    imm_sel     = IMM_I;
    wb_sel      = WB_ALU;
    reg_we      = 1'b0;
    addr_sel    = 1'b0;
    mem_we      = 1'b0;
    retired     = 1'b0;
    halted      = 1'b0;
    case (state_q)
      FETCH: begin
        ir_load     = hs;
        old_pc_load = hs;
        pc_load     = hs;  // Next PC ready before decode
        if (hs) state_d = DECODE;
      end
      DECODE: state_d = known ? EXECUTE : HALT;
      EXECUTE: begin
        state_d = WRITEBACK;
        case (opcode)
          OPC_OP: begin
            src_a  = SRC_A_REG;
            src_b  = SRC_B_REG;
            alu_op = arith_op;
          end
          OPC_OP_IMM: begin
            src_a  = SRC_A_REG;
            src_b  = SRC_B_IMM;
            alu_op = arith_op;
          end
          OPC_LUI: begin
            src_a   = SRC_A_ZERO;
            src_b   = SRC_B_IMM;
            imm_sel = IMM_U;
            alu_op  = ALU_PASS_B;
          end
          OPC_AUIPC: begin
            src_a   = SRC_A_OLD_PC;
            src_b   = SRC_B_IMM;
            imm_sel = IMM_U;
          end
          OPC_JAL: begin
            src_a   = SRC_A_OLD_PC;
            src_b   = SRC_B_IMM;
            imm_sel = IMM_J;
            pc_load = 1'b1;
          end
          OPC_JALR: begin
            src_a   = SRC_A_REG;
            src_b   = SRC_B_IMM;
            pc_load = 1'b1;
          end
          OPC_BRANCH: begin
            src_a   = SRC_A_OLD_PC;
            src_b   = SRC_B_IMM;
            imm_sel = IMM_B;
            pc_load = branch_taken;
            retired = 1'b1;  // Branches finish here
            state_d = FETCH;
          end
          OPC_LOAD, OPC_STORE: begin
            src_a   = SRC_A_REG;
            src_b   = SRC_B_IMM;
            imm_sel = is_store ? IMM_S : IMM_I;
            state_d = MEM;
          end
          default: state_d = HALT;
        endcase
      end
      MEM: begin
        src_a    = SRC_A_REG;  // Keep the address steady in alu_q
        src_b    = SRC_B_IMM;
        imm_sel  = is_store ? IMM_S : IMM_I;
        addr_sel = 1'b1;
        mem_we   = is_store;
        retired  = hs & is_store;
        if (hs) state_d = is_store ? FETCH : WRITEBACK;
      end
      WRITEBACK: begin
        reg_we  = 1'b1;
        retired = 1'b1;
        if (opcode == OPC_JAL || opcode == OPC_JALR) begin
          wb_sel = WB_PC4;
        end else if (opcode == OPC_LOAD) begin
          wb_sel = WB_MEM;
        end
        state_d = FETCH;
      end
      default: halted = 1'b1;  // Parked until reset
    endcase
  end

endmodule

//--- hdl/rv_execute.sv
// Immediates, ALU and branch compare
`timescale 1ns/1ps

module rv_execute (
  input  rv_core_pkg::instr_u   instr,
  input  logic [31:0]           rs1_data,
  input  logic [31:0]           rs2_data,
  input  logic [31:0]           pc,
  input  logic [31:0]           old_pc,
  input  rv_core_pkg::alu_op_e  alu_op,
  input  rv_core_pkg::src_a_e   src_a,
  input  rv_core_pkg::src_b_e   src_b,
  input  rv_core_pkg::imm_sel_e imm_sel,
  output logic [31:0]           alu_result,
  output logic                  branch_taken
);
  import rv_core_pkg::*;

  logic [31:0] imm;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_raw;
  logic [4:0]  shamt;
  logic        jalr_target;

  always_comb begin
    case (imm_sel)
      IMM_S: imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      IMM_B: imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_lo[0],
                    instr.s_fmt.imm_hi[5:0], instr.s_fmt.imm_lo[4:1], 1'b0};
      IMM_U: imm = {instr.u_fmt.imm20, 12'b0};
      IMM_J: imm = {{12{instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20[7:0],
                    instr.u_fmt.imm20[8], instr.u_fmt.imm20[18:9], 1'b0};
      default: imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    endcase
  end

  always_comb begin
    case (src_a)
      SRC_A_PC:     op_a = pc;
      SRC_A_OLD_PC: op_a = old_pc;
      SRC_A_ZERO:   op_a = '0;
      default:      op_a = rs1_data;
    endcase
    case (src_b)
      SRC_B_IMM:  op_b = imm;
      SRC_B_FOUR: op_b = 32'd4;
      default:    op_b = rs2_data;
    endcase
  end

  assign shamt = op_b[4:0];

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_raw = op_a - op_b;
      ALU_SLL:    alu_raw = op_a << shamt;
      ALU_SLT:    alu_raw = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_raw = {31'b0, op_a < op_b};
      ALU_XOR:    alu_raw = op_a ^ op_b;
      ALU_SRL:    alu_raw = op_a >> shamt;
      ALU_SRA:    alu_raw = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_raw = op_a | op_b;
      ALU_AND:    alu_raw = op_a & op_b;
      ALU_PASS_B: alu_raw = op_b;
      default:    alu_raw = op_a + op_b;
    endcase
  end

  // Only the JALR target add, not the fetch increment
  assign jalr_target = (instr.i_fmt.opcode == OPC_JALR) && (src_a == SRC_A_REG);
  assign alu_result  = jalr_target ? {alu_raw[31:1], 1'b0} : alu_raw;

  always_comb begin
    case (instr.s_fmt.funct3)
      3'b000:  branch_taken = (rs1_data == rs2_data);
      3'b001:  branch_taken = (rs1_data != rs2_data);
      3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  branch_taken = (rs1_data < rs2_data);
      3'b111:  branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;  // 010 and 011 are not branches
    endcase
  end

endmodule

//--- hdl/rv_result.sv
// PC, instruction and result registers
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_result (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ir_load,
  input  logic                 pc_load,
  input  logic                 old_pc_load,
  input  rv_core_pkg::wb_sel_e wb_sel,
  input  logic [31:0]          alu_result,
  input  logic [31:0]          mem_rdata,
  input  logic                 addr_sel,
  output rv_core_pkg::instr_u  instr,
  output logic [31:0]          pc,
  output logic [31:0]          old_pc,
  output logic [31:0]          alu_q,
  output logic [31:0]          wb_data,
  output logic [31:0]          mem_addr
);
  import rv_core_pkg::*;

  logic [31:0] mdr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_ADDR;
      old_pc <= `RV_RESET_ADDR;  // Observed as the core pc output
    end else begin
      if (pc_load) pc <= alu_result;
      if (old_pc_load) old_pc <= pc;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_load) instr <= mem_rdata;
    alu_q <= alu_result;
    // Last capture in MEM is the handshake edge
    if (addr_sel) mdr_q <= mem_rdata;
  end

  always_comb begin
    case (wb_sel)
      WB_MEM:  wb_data = mdr_q;
      WB_PC4:  wb_data = old_pc + 32'd4;  // Link address
      default: wb_data = alu_q;
    endcase
  end

  assign mem_addr = addr_sel ? alu_q : pc;

endmodule

//--- hdl/rv_regfile.sv
// Integer register file
`timescale 1ns/1ps

`include "rv_core_config.svh"

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [4:0]  rd_addr,
  input  logic        rd_we,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [1:`RV_NUM_REGS-1];  // No storage behind x0

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

//--- hdl/rv_core.sv
// Multicycle RV32I core
`timescale 1ns/1ps

module rv_core (
  input  logic        clk,
  input  logic        rst_n,
  output logic        mem_valid,
  input  logic        mem_ready,
  output logic [31:0] mem_addr,
  output logic        mem_we,
  output logic [31:0] mem_wdata,
  input  logic [31:0] mem_rdata,
  output logic [31:0] pc,
  output logic        retired,
  output logic        halted
);
  import rv_core_pkg::*;

  instr_u      instr;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] fetch_pc;
  logic [31:0] old_pc;
  logic [31:0] alu_result;
  logic [31:0] wb_data;
  logic        branch_taken;
  logic        ir_load;
  logic        pc_load;
  logic        old_pc_load;
  logic        reg_we;
  logic        addr_sel;
  alu_op_e     alu_op;
  src_a_e      src_a;
  src_b_e      src_b;
  imm_sel_e    imm_sel;
  wb_sel_e     wb_sel;

  assign pc        = old_pc;    // Address of the instruction in flight
  assign mem_wdata = rs2_data;  // Store data straight from the rs2 port

  rv_decode i_decode (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr        (instr),
    .branch_taken (branch_taken),
    .mem_ready    (mem_ready),
    .state_q      (),
    .ir_load      (ir_load),
    .pc_load      (pc_load),
    .old_pc_load  (old_pc_load),
    .alu_op       (alu_op),
    .src_a        (src_a),
    .src_b        (src_b),
    .imm_sel      (imm_sel),
    .wb_sel       (wb_sel),
    .reg_we       (reg_we),
    .addr_sel     (addr_sel),
    .mem_valid    (mem_valid),
    .mem_we       (mem_we),
    .retired      (retired),
    .halted       (halted)
  );

  rv_execute i_execute (
    .instr        (instr),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .pc           (fetch_pc),
    .old_pc       (old_pc),
    .alu_op       (alu_op),
    .src_a        (src_a),
    .src_b        (src_b),
    .imm_sel      (imm_sel),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  rv_result i_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .ir_load      (ir_load),
    .pc_load      (pc_load),
    .old_pc_load  (old_pc_load),
    .wb_sel       (wb_sel),
    .alu_result   (alu_result),
    .mem_rdata    (mem_rdata),
    .addr_sel     (addr_sel),
    .instr        (instr),
    .pc           (fetch_pc),
    .old_pc       (old_pc),
    .alu_q        (),
    .wb_data      (wb_data),
    .mem_addr     (mem_addr)
  );

  rv_regfile i_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs1_addr     (instr.r_fmt.rs1),
    .rs2_addr     (instr.r_fmt.rs2),
    .rd_addr      (instr.r_fmt.rd),
    .rd_we        (reg_we),
    .rd_data      (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

endmodule

//--- dv/tb_rv_program.svh
// Test program and expected memory image

// Signed order from the sign bits, then magnitude
function automatic logic less_signed(input logic [31:0] x, input logic [31:0] y);
  if (x[31] != y[31]) return x[31];
  return x < y;
endfunction

function automatic logic [31:0] shift_right_arith(input logic [31:0] x, input int n);
  logic [31:0] fill;
  fill = x[31] ? ~(32'hFFFF_FFFF >> n) : 32'd0;  // Sign copies in the vacated bits
  return (x >> n) | fill;
endfunction

task automatic emit(input logic [31:0] word, input bit retires);
  mem[pc_word]     = word;
  exp_mem[pc_word] = word;
  if (retires) begin
    n_exec++;
    retire_pc.push_back(pc_word * 4);
  end
  pc_word++;
  n_instr++;
endtask

// SW to the next data word, which then must hold val
task automatic store_expect(input logic [4:0] rs, input logic [31:0] val, input int tag);
  emit(enc_s(data_addr[11:0], rs, 5'd0), 1'b1);
  exp_mem[data_addr >> 2] = val;
  exp_tag[data_addr >> 2] = tag;
  data_addr += 4;
endtask

// Marker store on a path that must be jumped over
task automatic skip_store();
  emit(enc_s(data_addr[11:0], 5'd8, 5'd0), 1'b0);
  data_addr += 4;
endtask

task automatic alu_r(input logic [6:0] f7, input logic [2:0] f3, input logic [31:0] val);
  emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3), 1'b1);
  store_expect(5'd3, val, 1);
endtask

task automatic alu_i(input logic [11:0] imm, input logic [2:0] f3, input logic [31:0] val);
  emit(enc_i(imm, 5'd1, f3, 5'd4, OPC_OP_IMM), 1'b1);
  store_expect(5'd4, val, 1);
endtask

task automatic branch_case(input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [2:0] f3, input bit taken);
  emit(enc_b(13'd8, rs2, rs1, f3), 1'b1);
  if (taken) skip_store();
  else store_expect(5'd8, 32'd1, 3);
endtask

task automatic load_program();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] p;
  a = 32'hF0F0_EFF0;
  b = 32'd5;
  emit(enc_u(20'hF0F0F, 5'd1, OPC_LUI), 1'b1);
  emit(enc_i(12'hFF0, 5'd1, 3'b000, 5'd1, OPC_OP_IMM), 1'b1);  // -16
  emit(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), 1'b1);
  store_expect(5'd1, a, 1);
  alu_r(7'h00, 3'b000, a + b);
  alu_r(7'h20, 3'b000, a - b);
  alu_r(7'h00, 3'b001, a << b[4:0]);
  alu_r(7'h00, 3'b010, {31'b0, less_signed(a, b)});
  alu_r(7'h00, 3'b011, {31'b0, a < b});
  alu_r(7'h00, 3'b100, a ^ b);
  alu_r(7'h00, 3'b101, a >> b[4:0]);
  alu_r(7'h20, 3'b101, shift_right_arith(a, b[4:0]));
  alu_r(7'h00, 3'b110, a | b);
  alu_r(7'h00, 3'b111, a & b);
  alu_i(12'hFFD, 3'b000, a + 32'hFFFF_FFFD);
  alu_i(12'h001, 3'b010, {31'b0, less_signed(a, 32'd1)});
  alu_i(12'hFFF, 3'b011, {31'b0, a < 32'hFFFF_FFFF});
  alu_i(12'h555, 3'b100, a ^ 32'h555);
  alu_i(12'h0F0, 3'b110, a | 32'h0F0);
  alu_i(12'h7FF, 3'b111, a & 32'h7FF);
  alu_i(12'h004, 3'b001, a << 4);
  alu_i(12'h008, 3'b101, a >> 8);
  alu_i(12'h408, 3'b101, shift_right_arith(a, 8));
  p = pc_word * 4;
  emit(enc_u(20'h12345, 5'd5, OPC_AUIPC), 1'b1);
  store_expect(5'd5, p + 32'h1234_5000, 1);
  emit(enc_i(12'd99, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 1'b1);  // x0 stays zero
  store_expect(5'd0, 32'd0, 2);
  emit(enc_i(12'h200, 5'd0, 3'b010, 5'd6, OPC_LOAD), 1'b1);
  store_expect(5'd6, a, 2);
  emit(enc_i(12'h208, 5'd0, 3'b010, 5'd7, OPC_LOAD), 1'b1);
  store_expect(5'd7, a - b, 2);
  emit(enc_i(12'd1, 5'd0, 3'b000, 5'd8, OPC_OP_IMM), 1'b1);  // Marker value
  branch_case(5'd2, 5'd2, 3'b000, b == b);
  branch_case(5'd2, 5'd2, 3'b001, b != b);
  branch_case(5'd1, 5'd2, 3'b100, less_signed(a, b));
  branch_case(5'd1, 5'd2, 3'b101, !less_signed(a, b));
  branch_case(5'd2, 5'd1, 3'b110, b < a);
  branch_case(5'd2, 5'd1, 3'b111, b >= a);
  p = pc_word * 4;
  emit(enc_j(21'd8, 5'd9), 1'b1);
  skip_store();
  store_expect(5'd9, p + 32'd4, 3);
  p = pc_word * 4;
  emit(enc_u(20'h00000, 5'd10, OPC_AUIPC), 1'b1);
  emit(enc_i(12'd13, 5'd10, 3'b000, 5'd11, OPC_JALR), 1'b1);  // Odd target
  skip_store();
  store_expect(5'd11, p + 32'd8, 3);
  emit(32'h0000_0073, 1'b0);  // ECALL halts in decode
endtask

//--- dv/tb_rv_core.sv
// RV32I core testbench
`timescale 1ns/1ps

`include "rv_core_config.svh"

module tb_rv_core;
  import rv_core_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        mem_valid;
  logic        mem_ready;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic [31:0] pc;
  logic        retired;
  logic        halted;

  logic [31:0] mem [0:255];
  logic [31:0] exp_mem [0:255];
  int          exp_tag [0:255];
  int          errs [0:4];
  string       test_name [0:4];
  logic [31:0] retire_pc [$];
  int          pc_word;
  int          data_addr;
  int          n_instr;
  int          n_exec;
  int          n_retired;
  int          cycles;
  int          limit;
  int unsigned rng_state;
  logic [31:0] req_addr;
  logic [31:0] req_wdata;
  logic        req_we;
  bit          pending;
  bit          seen_first;
  int          wait_cnt;

  rv_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .retired   (retired),
    .halted    (halted)
  );

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic int unsigned lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return (rng_state >> 16) & 32'h7FFF;
  endfunction

  task automatic record_error(input int tag, input string msg);
    errs[tag]++;
    $display("FAILED at %0t ns: %s", $time, msg);
  endtask

  `include "tb_rv_program.svh"

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Memory model that answers one step after each edge
  always @(posedge clk) begin
    #1;
    if (!rst_n) begin
      assert (mem_valid !== 1'b1) else record_error(0, "mem_valid high during reset");
      mem_ready = 1'b0;
      pending   = 1'b0;
    end else begin
      if (mem_ready) begin
        if (req_we) mem[req_addr[9:2]] = req_wdata;
        mem_ready = 1'b0;
        pending   = 1'b0;
      end
      if (pending) begin
        assert (mem_valid && mem_addr == req_addr && mem_we == req_we &&
                mem_wdata == req_wdata)
          else record_error(0, "request changed while waiting for mem_ready");
      end else if (mem_valid) begin
        pending   = 1'b1;
        req_addr  = mem_addr;
        req_we    = mem_we;
        req_wdata = mem_wdata;
        wait_cnt  = lcg_next() % 4;
        if (!seen_first) begin
          seen_first = 1'b1;
          assert (mem_addr == `RV_RESET_ADDR && !mem_we)
            else record_error(0, $sformatf("first request at 0x%08h, write %0b",
                                           mem_addr, mem_we));
        end
      end
      if (pending) begin
        if (wait_cnt == 0) begin
          mem_ready = 1'b1;
          mem_rdata = mem[req_addr[9:2]];
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // Each retiring instruction shows its own address on pc
  always @(negedge clk) begin
    if (rst_n && retired) begin
      if (n_retired < retire_pc.size()) begin
        assert (pc == retire_pc[n_retired])
          else record_error(3, $sformatf("retired pc 0x%08h, expected 0x%08h",
                                         pc, retire_pc[n_retired]));
      end
      n_retired++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: core did not halt within %0d cycles", limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int total;
    int passed;
    rst_n      = 1'b0;
    mem_ready  = 1'b0;
    mem_rdata  = 32'd0;
    rng_state  = 49;
    limit      = 100000;
    test_name  = '{"reset_handshake", "alu_results", "load_store", "control_flow", "halt"};
    for (int i = 0; i < 256; i++) begin
      mem[i]     = 32'hA5A5_0000 ^ (i * 4);  // Fill tied to the address
      exp_mem[i] = mem[i];
      exp_tag[i] = 3;
    end
    pc_word   = 0;
    data_addr = 32'h200;
    load_program();
    limit = n_instr * (5 + 3) * 2 + 10 + 40;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    while (!halted) @(negedge clk);
    repeat (20) begin
      @(negedge clk);
      assert (halted && !mem_valid) else record_error(4, "core left halt or requested memory");
    end
    assert (n_retired == n_exec)
      else record_error(4, $sformatf("%0d retired, expected %0d", n_retired, n_exec));
    for (int i = 0; i < 256; i++) begin
      assert (mem[i] == exp_mem[i])
        else record_error(exp_tag[i], $sformatf("mem[0x%03h] = 0x%08h, expected 0x%08h",
                                                i * 4, mem[i], exp_mem[i]));
    end
    total  = 0;
    passed = 0;
    for (int t = 0; t < 5; t++) begin
      $display("%-16s %s (%0d errors)", test_name[t], (errs[t] == 0) ? "passed" : "failed",
               errs[t]);
      total += errs[t];
      if (errs[t] == 0) passed++;
    end
    $display("%0d of 5 tests passed, %0d errors", passed, total);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hdl
+incdir+dv
hdl/rv_core_pkg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_regfile.sv
hdl/rv_core.sv
dv/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_core_pkg.sv
      - hdl/rv_decode.sv
      - hdl/rv_execute.sv
      - hdl/rv_result.sv
      - hdl/rv_regfile.sv
      - hdl/rv_core.sv
  - target: test
    include_dirs:
      - hdl
      - dv
    files:
      - dv/tb_rv_core.sv
